/* source/rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Data and address width
`define RV_XLEN 32

// Data memory size in 32-bit words
`define RV_DMEM_WORDS 64

// First PC after reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* source/rv_pkg.sv */
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // Upper bit is funct7[5], lower bits are funct3
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } alu_op_e;

    typedef enum logic [1:0] {ACC_BYTE = 2'b00, ACC_HALF = 2'b01, ACC_WORD = 2'b10} access_e;
    typedef enum logic [1:0] {A_REG = 2'b00, A_PC = 2'b01, A_ZERO = 2'b10} a_sel_e;
    typedef enum logic [1:0] {B_REG = 2'b00, B_IMM = 2'b01, B_FOUR = 2'b10} b_sel_e;
    typedef enum logic [1:0] {PC_PLUS4 = 2'b00, PC_OFFSET = 2'b01, PC_INDIRECT = 2'b11} pc_sel_e;
    typedef enum logic [1:0] {WB_ALU = 2'b00, WB_MEM = 2'b01, WB_PC4 = 2'b10} wb_sel_e;

    typedef struct packed {
        alu_op_e               alu_op;
        a_sel_e                a_sel;
        b_sel_e                b_sel;
        logic                  branch;       // Conditional branch
        logic [2:0]            branch_cond;  // Branch funct3
        pc_sel_e               pc_sel;       // Jump target select
        logic                  mem_rd;
        logic                  mem_wr;
        access_e               mem_access;
        logic                  mem_unsigned;
        logic                  reg_wr;
        wb_sel_e               wb_sel;
        logic [4:0]            rd;
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic [`RV_XLEN-1:0]   imm;
    } ctrl_t;

    typedef struct packed {
        logic                  valid;
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_XLEN-1:0]   next_pc;
        logic                  reg_wr;
        logic [4:0]            rd;
        logic [`RV_XLEN-1:0]   wr_data;
    } retire_t;

endpackage

`default_nettype wire

/* source/rv_decode.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_defs.svh"

module rv_decode (
    input  wire logic [31:0]  i_inst,  // Instruction word
    output rv_pkg::ctrl_t     o_ctrl   // Decoded control
);

    logic [`RV_XLEN-1:0] imm;

    // Immediate format follows the opcode
    always_comb
    begin
        case (i_inst[6:0])
            rv_pkg::OPC_LUI,
            rv_pkg::OPC_AUIPC:  imm = {i_inst[31:12], 12'b0};
            rv_pkg::OPC_JAL:    imm = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12],
                                       i_inst[20], i_inst[30:21], 1'b0};
            rv_pkg::OPC_BRANCH: imm = {{19{i_inst[31]}}, i_inst[31], i_inst[7],
                                       i_inst[30:25], i_inst[11:8], 1'b0};
            rv_pkg::OPC_STORE:  imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
            rv_pkg::OPC_JALR,
            rv_pkg::OPC_LOAD,
            rv_pkg::OPC_OP_IMM: imm = {{20{i_inst[31]}}, i_inst[31:20]};
            default:            imm = '0;
        endcase
    end

    always_comb
    begin
        // Safe defaults give a no-op with PC+4
        o_ctrl.alu_op       = rv_pkg::ALU_ADD;
        o_ctrl.a_sel        = rv_pkg::A_REG;
        o_ctrl.b_sel        = rv_pkg::B_REG;
        o_ctrl.branch       = 1'b0;
        o_ctrl.branch_cond  = i_inst[14:12];
        o_ctrl.pc_sel       = rv_pkg::PC_PLUS4;
        o_ctrl.mem_rd       = 1'b0;
        o_ctrl.mem_wr       = 1'b0;
        o_ctrl.mem_access   = rv_pkg::ACC_WORD;
        o_ctrl.mem_unsigned = 1'b0;
        o_ctrl.reg_wr       = 1'b0;
        o_ctrl.wb_sel       = rv_pkg::WB_ALU;
        o_ctrl.rd           = i_inst[11:7];
        o_ctrl.rs1          = i_inst[19:15];
        o_ctrl.rs2          = i_inst[24:20];
        o_ctrl.imm          = imm;

        unique casez ({i_inst[31:25], i_inst[14:12], i_inst[6:0]})
            {10'b???????_???, rv_pkg::OPC_LUI}:     // LUI
            begin
                o_ctrl.a_sel  = rv_pkg::A_ZERO;
                o_ctrl.b_sel  = rv_pkg::B_IMM;
                o_ctrl.reg_wr = 1'b1;
            end

            {10'b???????_???, rv_pkg::OPC_AUIPC}:   // AUIPC
            begin
                o_ctrl.a_sel  = rv_pkg::A_PC;
                o_ctrl.b_sel  = rv_pkg::B_IMM;
                o_ctrl.reg_wr = 1'b1;
            end

            {10'b???????_???, rv_pkg::OPC_JAL}:     // JAL
            begin
                o_ctrl.wb_sel = rv_pkg::WB_PC4;
                o_ctrl.reg_wr = 1'b1;
                o_ctrl.pc_sel = rv_pkg::PC_OFFSET;
            end

            {10'b???????_000, rv_pkg::OPC_JALR}:    // JALR, target from the ALU
            begin
                o_ctrl.b_sel  = rv_pkg::B_IMM;
                o_ctrl.wb_sel = rv_pkg::WB_PC4;
                o_ctrl.reg_wr = 1'b1;
                o_ctrl.pc_sel = rv_pkg::PC_INDIRECT;
            end

            {10'b???????_000, rv_pkg::OPC_BRANCH},  // BEQ
            {10'b???????_001, rv_pkg::OPC_BRANCH},  // BNE
            {10'b???????_100, rv_pkg::OPC_BRANCH},  // BLT
            {10'b???????_101, rv_pkg::OPC_BRANCH},  // BGE
            {10'b???????_110, rv_pkg::OPC_BRANCH},  // BLTU
            {10'b???????_111, rv_pkg::OPC_BRANCH}:  // BGEU
                o_ctrl.branch = 1'b1;

            {10'b???????_000, rv_pkg::OPC_LOAD},    // LB
            {10'b???????_001, rv_pkg::OPC_LOAD},    // LH
            {10'b???????_010, rv_pkg::OPC_LOAD},    // LW
            {10'b???????_100, rv_pkg::OPC_LOAD},    // LBU
            {10'b???????_101, rv_pkg::OPC_LOAD}:    // LHU
            begin
                o_ctrl.b_sel        = rv_pkg::B_IMM;
                o_ctrl.wb_sel       = rv_pkg::WB_MEM;
                o_ctrl.reg_wr       = 1'b1;
                o_ctrl.mem_rd       = 1'b1;
                o_ctrl.mem_unsigned = i_inst[14];
                o_ctrl.mem_access   = rv_pkg::access_e'(i_inst[13:12]);
            end

            {10'b???????_000, rv_pkg::OPC_STORE},   // SB
            {10'b???????_001, rv_pkg::OPC_STORE},   // SH
            {10'b???????_010, rv_pkg::OPC_STORE}:   // SW
            begin
                o_ctrl.b_sel      = rv_pkg::B_IMM;
                o_ctrl.mem_wr     = 1'b1;
                o_ctrl.mem_access = rv_pkg::access_e'(i_inst[13:12]);
            end

            {10'b???????_000, rv_pkg::OPC_OP_IMM},  // ADDI
            {10'b???????_010, rv_pkg::OPC_OP_IMM},  // SLTI
            {10'b???????_011, rv_pkg::OPC_OP_IMM},  // SLTIU
            {10'b???????_100, rv_pkg::OPC_OP_IMM},  // XORI
            {10'b???????_110, rv_pkg::OPC_OP_IMM},  // ORI
            {10'b???????_111, rv_pkg::OPC_OP_IMM}:  // ANDI
            begin
                o_ctrl.b_sel  = rv_pkg::B_IMM;
                o_ctrl.reg_wr = 1'b1;
                o_ctrl.alu_op = rv_pkg::alu_op_e'({1'b0, i_inst[14:12]});
            end

            {10'b0000000_001, rv_pkg::OPC_OP_IMM},  // SLLI
            {10'b0000000_101, rv_pkg::OPC_OP_IMM},  // SRLI
            {10'b0100000_101, rv_pkg::OPC_OP_IMM}:  // SRAI
            begin
                o_ctrl.b_sel  = rv_pkg::B_IMM;
                o_ctrl.reg_wr = 1'b1;
                o_ctrl.alu_op = rv_pkg::alu_op_e'({i_inst[30], i_inst[14:12]});
            end

            {10'b0000000_000, rv_pkg::OPC_OP},      // ADD
            {10'b0100000_000, rv_pkg::OPC_OP},      // SUB
            {10'b0000000_001, rv_pkg::OPC_OP},      // SLL
            {10'b0000000_010, rv_pkg::OPC_OP},      // SLT
            {10'b0000000_011, rv_pkg::OPC_OP},      // SLTU
            {10'b0000000_100, rv_pkg::OPC_OP},      // XOR
            {10'b0000000_101, rv_pkg::OPC_OP},      // SRL
            {10'b0100000_101, rv_pkg::OPC_OP},      // SRA
            {10'b0000000_110, rv_pkg::OPC_OP},      // OR
            {10'b0000000_111, rv_pkg::OPC_OP}:      // AND
            begin
                o_ctrl.reg_wr = 1'b1;
                o_ctrl.alu_op = rv_pkg::alu_op_e'({i_inst[30], i_inst[14:12]});
            end

            default: ;                              // MUL/DIV and unknown fall here
        endcase
    end

endmodule

`default_nettype wire

/* source/rv_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_defs.svh"

module rv_regfile (
    input  wire logic                 i_clock,
    input  wire logic                 i_reset,
    input  wire logic                 i_wr_enable,  // Write strobe
    input  wire logic [4:0]           i_wr_addr,
    input  wire logic [`RV_XLEN-1:0]  i_wr_data,
    input  wire logic [4:0]           i_rd_addr_a,
    input  wire logic [4:0]           i_rd_addr_b,
    output logic      [`RV_XLEN-1:0]  o_rd_data_a,
    output logic      [`RV_XLEN-1:0]  o_rd_data_b
);

    logic [`RV_XLEN-1:0] regs [1:31];  // No storage behind x0

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (i_wr_enable && (i_wr_addr != 5'd0))
        begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    assign o_rd_data_a = (i_rd_addr_a == 5'd0) ? '0 : regs[i_rd_addr_a];
    assign o_rd_data_b = (i_rd_addr_b == 5'd0) ? '0 : regs[i_rd_addr_b];

endmodule

`default_nettype wire

/* source/rv_execute.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_defs.svh"

module rv_execute (
    input  rv_pkg::ctrl_t             i_ctrl,
    input  wire logic [`RV_XLEN-1:0]  i_pc,
    input  wire logic [`RV_XLEN-1:0]  i_rs1_data,
    input  wire logic [`RV_XLEN-1:0]  i_rs2_data,
    output logic      [`RV_XLEN-1:0]  o_alu_result,
    output logic      [`RV_XLEN-1:0]  o_pc_plus4,
    output logic      [`RV_XLEN-1:0]  o_next_pc
);

    logic [`RV_XLEN-1:0] operand_a;
    logic [`RV_XLEN-1:0] operand_b;
    logic [4:0]          shamt;
    logic                is_equal;
    logic                is_less_signed;
    logic                is_less_unsigned;
    logic                taken;

    always_comb
    begin
        case (i_ctrl.a_sel)
            rv_pkg::A_PC:   operand_a = i_pc;
            rv_pkg::A_ZERO: operand_a = '0;
            default:        operand_a = i_rs1_data;
        endcase

        case (i_ctrl.b_sel)
            rv_pkg::B_IMM:  operand_b = i_ctrl.imm;
            rv_pkg::B_FOUR: operand_b = `RV_XLEN'd4;
            default:        operand_b = i_rs2_data;
        endcase
    end

    assign shamt = operand_b[4:0];

    always_comb
    begin
        case (i_ctrl.alu_op)
            rv_pkg::ALU_SUB:  o_alu_result = operand_a - operand_b;
            rv_pkg::ALU_SLL:  o_alu_result = operand_a << shamt;
            rv_pkg::ALU_SLT:  o_alu_result = {31'b0, $signed(operand_a) < $signed(operand_b)};
            rv_pkg::ALU_SLTU: o_alu_result = {31'b0, operand_a < operand_b};
            rv_pkg::ALU_XOR:  o_alu_result = operand_a ^ operand_b;
            rv_pkg::ALU_SRL:  o_alu_result = operand_a >> shamt;
            rv_pkg::ALU_SRA:  o_alu_result = $signed(operand_a) >>> shamt;
            rv_pkg::ALU_OR:   o_alu_result = operand_a | operand_b;
            rv_pkg::ALU_AND:  o_alu_result = operand_a & operand_b;
            default:          o_alu_result = operand_a + operand_b;
        endcase
    end

    // Branch flags always compare the two registers
    assign is_equal         = (i_rs1_data == i_rs2_data);
    assign is_less_signed   = ($signed(i_rs1_data) < $signed(i_rs2_data));
    assign is_less_unsigned = (i_rs1_data < i_rs2_data);

    always_comb
    begin
        case (i_ctrl.branch_cond)
            3'b000:  taken = is_equal;           // BEQ
            3'b001:  taken = !is_equal;          // BNE
            3'b100:  taken = is_less_signed;     // BLT
            3'b101:  taken = !is_less_signed;    // BGE, equal counts
            3'b110:  taken = is_less_unsigned;   // BLTU
            3'b111:  taken = !is_less_unsigned;  // BGEU, equal counts
            default: taken = 1'b0;
        endcase
        if (!i_ctrl.branch)
            taken = 1'b0;
    end

    assign o_pc_plus4 = i_pc + `RV_XLEN'd4;

    always_comb
    begin
        case (i_ctrl.pc_sel)
            rv_pkg::PC_OFFSET:   o_next_pc = i_pc + i_ctrl.imm;
            rv_pkg::PC_INDIRECT: o_next_pc = {o_alu_result[`RV_XLEN-1:1], 1'b0};  // rs1+imm
            default:             o_next_pc = taken ? (i_pc + i_ctrl.imm) : o_pc_plus4;
        endcase
    end

endmodule

`default_nettype wire

/* source/rv_result.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_defs.svh"

module rv_result (
    input  wire logic                 i_clock,
    input  wire logic                 i_reset,
    input  rv_pkg::ctrl_t             i_ctrl,
    input  wire logic [`RV_XLEN-1:0]  i_addr,        // ALU result
    input  wire logic [`RV_XLEN-1:0]  i_store_data,  // rs2 value
    input  wire logic [`RV_XLEN-1:0]  i_pc_plus4,
    input  wire logic                 i_commit,      // Accepted strobe
    output logic      [`RV_XLEN-1:0]  o_wr_data
);

    localparam int INDEX_W = $clog2(`RV_DMEM_WORDS);

    logic [`RV_XLEN-1:0] mem [`RV_DMEM_WORDS];
    logic [INDEX_W-1:0]  index;
    logic [1:0]          offset;
    logic [3:0]          lane_en;
    logic [`RV_XLEN-1:0] lane_data;
    logic [`RV_XLEN-1:0] rd_word;
    logic [7:0]          rd_byte;
    logic [15:0]         rd_half;
    logic [`RV_XLEN-1:0] load_data;

    assign index  = i_addr[INDEX_W+1:2];  // Upper address bits ignored
    assign offset = i_addr[1:0];

    // Replicate store data and pick lanes
    always_comb
    begin
        case (i_ctrl.mem_access)
            rv_pkg::ACC_BYTE:
            begin
                lane_en   = 4'b0001 << offset;
                lane_data = {4{i_store_data[7:0]}};
            end
            rv_pkg::ACC_HALF:
            begin
                lane_en   = offset[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{i_store_data[15:0]}};
            end
            default:
            begin
                lane_en   = 4'b1111;
                lane_data = i_store_data;
            end
        endcase
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            for (int w = 0; w < `RV_DMEM_WORDS; w++)
                mem[w] <= '0;
        end
        else if (i_commit && i_ctrl.mem_wr)
        begin
            for (int b = 0; b < 4; b++)
                if (lane_en[b])
                    mem[index][8*b +: 8] <= lane_data[8*b +: 8];
        end
    end

    assign rd_word = mem[index];
    assign rd_byte = rd_word[8*offset +: 8];
    assign rd_half = offset[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb
    begin
        case (i_ctrl.mem_access)
            rv_pkg::ACC_BYTE: load_data = {{24{rd_byte[7] & !i_ctrl.mem_unsigned}}, rd_byte};
            rv_pkg::ACC_HALF: load_data = {{16{rd_half[15] & !i_ctrl.mem_unsigned}}, rd_half};
            default:          load_data = rd_word;
        endcase
        if (!i_ctrl.mem_rd)
            load_data = '0;
    end

    always_comb
    begin
        case (i_ctrl.wb_sel)
            rv_pkg::WB_MEM: o_wr_data = load_data;
            rv_pkg::WB_PC4: o_wr_data = i_pc_plus4;
            default:        o_wr_data = i_addr;  // ALU result
        endcase
    end

endmodule

`default_nettype wire

/* source/rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_defs.svh"

module rv_core (
    input  wire logic                 i_clock,
    input  wire logic                 i_reset,
    input  wire logic                 i_inst_valid,  // One-cycle instruction strobe
    input  wire logic [31:0]          i_inst,
    output logic      [`RV_XLEN-1:0]  o_pc,          // PC expected next
    output rv_pkg::retire_t           o_retire
);

    rv_pkg::ctrl_t       ctrl;
    rv_pkg::retire_t     retire_q;
    logic [`RV_XLEN-1:0] pc_q;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] alu_result;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] next_pc;
    logic [`RV_XLEN-1:0] wr_data;

    rv_decode rv_decode_inst (
        .i_inst (i_inst),
        .o_ctrl (ctrl)
    );

    rv_regfile rv_regfile_inst (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_wr_enable (i_inst_valid & ctrl.reg_wr),
        .i_wr_addr   (ctrl.rd),
        .i_wr_data   (wr_data),
        .i_rd_addr_a (ctrl.rs1),
        .i_rd_addr_b (ctrl.rs2),
        .o_rd_data_a (rs1_data),
        .o_rd_data_b (rs2_data)
    );

    rv_execute rv_execute_inst (
        .i_ctrl       (ctrl),
        .i_pc         (pc_q),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .o_alu_result (alu_result),
        .o_pc_plus4   (pc_plus4),
        .o_next_pc    (next_pc)
    );

    rv_result rv_result_inst (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_ctrl       (ctrl),
        .i_addr       (alu_result),
        .i_store_data (rs2_data),
        .i_pc_plus4   (pc_plus4),
        .i_commit     (i_inst_valid),
        .o_wr_data    (wr_data)
    );

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            pc_q     <= `RV_RESET_PC;
            retire_q <= '0;
        end
        else
        begin
            retire_q.valid <= i_inst_valid;  // Record fields hold between strobes
            if (i_inst_valid)
            begin
                pc_q             <= next_pc;
                retire_q.pc      <= pc_q;
                retire_q.next_pc <= next_pc;
                retire_q.reg_wr  <= ctrl.reg_wr;
                retire_q.rd      <= ctrl.rd;
                retire_q.wr_data <= wr_data;
            end
        end
    end

    assign o_pc     = pc_q;
    assign o_retire = retire_q;

endmodule

`default_nettype wire

/* sim/rv_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_defs.svh"

module rv_core_tb;

    localparam int RETIRE_TIMEOUT = 8;  // Cycles allowed for one retire

    logic                i_clock;
    logic                i_reset;
    logic                i_inst_valid;
    logic [31:0]         i_inst;
    logic [`RV_XLEN-1:0] o_pc;
    rv_pkg::retire_t     o_retire;

    integer              seed;
    integer              fd;
    integer              fields;
    integer              gap;
    integer              cycles;
    integer              count;
    string               line;
    logic [31:0]         inst_word;
    logic [31:0]         exp_reg_wr;
    logic [31:0]         exp_rd;
    logic [31:0]         exp_wr_data;
    logic [31:0]         exp_next_pc;
    logic [31:0]         exp_pc;       // PC the core should hold now

    rv_core rv_core_inst (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_inst_valid (i_inst_valid),
        .i_inst       (i_inst),
        .o_pc         (o_pc),
        .o_retire     (o_retire)
    );

    always #10 i_clock = ~i_clock;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
            abort_run($sformatf("error: %s is 0x%08h, expected 0x%08h", name, actual, expected));
    endtask

    // Junk word on the bus with the strobe low so nothing may move
    task idle_cycle;
        i_inst = $random(seed);
        @(negedge i_clock);
        check_value("o_retire.valid", {31'b0, o_retire.valid}, 32'h0);
        check_value("o_pc", o_pc, exp_pc);
    endtask

    task execute_line;
        i_inst       = inst_word;
        i_inst_valid = 1'b1;
        @(negedge i_clock);
        i_inst_valid = 1'b0;
        cycles       = 0;
        while (!o_retire.valid)
        begin
            if (cycles >= RETIRE_TIMEOUT)
                abort_run($sformatf("No retire seen for instruction %0d (0x%08h)",
                                    count, inst_word));
            @(negedge i_clock);
            cycles++;
        end
        check_value($sformatf("inst %0d o_retire.pc", count), o_retire.pc, exp_pc);
        check_value($sformatf("inst %0d o_retire.next_pc", count), o_retire.next_pc,
                    exp_next_pc);
        check_value($sformatf("inst %0d o_retire.reg_wr", count),
                    {31'b0, o_retire.reg_wr}, exp_reg_wr);
        if (exp_reg_wr[0])
        begin
            check_value($sformatf("inst %0d o_retire.rd", count), {27'b0, o_retire.rd}, exp_rd);
            check_value($sformatf("inst %0d o_retire.wr_data", count), o_retire.wr_data,
                        exp_wr_data);
        end
        check_value($sformatf("inst %0d o_pc", count), o_pc, exp_next_pc);
        exp_pc = exp_next_pc;
        count++;
    endtask

    initial
    begin
        seed         = 32'hcd8f;
        i_clock      = 1'b0;
        i_reset      = 1'b1;
        i_inst_valid = 1'b0;
        i_inst       = '0;
        exp_pc       = `RV_RESET_PC;
        count        = 0;

        repeat (3) @(posedge i_clock);
        @(negedge i_clock);
        check_value("o_pc", o_pc, `RV_RESET_PC);
        check_value("o_retire.valid", {31'b0, o_retire.valid}, 32'h0);
        i_reset = 1'b0;
        idle_cycle();
        idle_cycle();

        fd = $fopen("sim/rv_core_stimulus.txt", "r");
        if (fd == 0)
            abort_run("Could not open the stimulus file sim/rv_core_stimulus.txt");

        while ($fgets(line, fd) != 0)
        begin
            if (line.len() > 1 && line[0] != "#")  // Skip comments and blank lines
            begin
                fields = $sscanf(line, "%h %h %h %h %h", inst_word, exp_reg_wr, exp_rd,
                                 exp_wr_data, exp_next_pc);
                if (fields != 5)
                    abort_run($sformatf("Stimulus entry %0d has %0d fields instead of 5",
                                        count, fields));
                gap = $random(seed) & 3;
                repeat (gap) idle_cycle();
                execute_line();
            end
        end
        $fclose(fd);

        if (count == 0)
        begin
            abort_run("The stimulus file holds no instructions");
        end
        else
        begin
            idle_cycle();
            idle_cycle();
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sim/rv_core_stimulus.txt */
# Columns, all hex: instruction, reg_wr, rd, wr_data, next_pc
# Text after the fifth column names the instruction
800000b7 1 01 80000000 00000004  lui   x1, 0x80000
00001117 1 02 00001004 00000008  auipc x2, 0x1
ffb00193 1 03 fffffffb 0000000c  addi  x3, x0, -5
7f300213 1 04 000007f3 00000010  addi  x4, x0, 0x7f3
0011a293 1 05 00000001 00000014  slti  x5, x3, 1
0011b313 1 06 00000000 00000018  sltiu x6, x3, 1
fff24393 1 07 fffff80c 0000001c  xori  x7, x4, -1
00c26413 1 08 000007ff 00000020  ori   x8, x4, 0xc
0f01f493 1 09 000000f0 00000024  andi  x9, x3, 0xf0
00418533 1 0a 000007ee 00000028  add   x10, x3, x4
404185b3 1 0b fffff808 0000002c  sub   x11, x3, x4
00521633 1 0c 00000fe6 00000030  sll   x12, x4, x5
4040d693 1 0d f8000000 00000034  srai  x13, x1, 4
0040d733 1 0e 00001000 00000038  srl   x14, x1, x4
4051d7b3 1 0f fffffffd 0000003c  sra   x15, x3, x5
0041a833 1 10 00000001 00000040  slt   x16, x3, x4
0041b8b3 1 11 00000000 00000044  sltu  x17, x3, x4
00120013 1 00 000007f4 00000048  addi  x0, x4, 1
00000933 1 12 00000000 0000004c  add   x18, x0, x0
04000a13 1 14 00000040 00000050  addi  x20, x0, 0x40
007a2023 0 00 00000000 00000054  sw    x7, 0(x20)
004a1123 0 00 00000000 00000058  sh    x4, 2(x20)
003a00a3 0 00 00000000 0000005c  sb    x3, 1(x20)
000a2a83 1 15 07f3fb0c 00000060  lw    x21, 0(x20)
000a1b03 1 16 fffffb0c 00000064  lh    x22, 0(x20)
000a5b83 1 17 0000fb0c 00000068  lhu   x23, 0(x20)
001a0c03 1 18 fffffffb 0000006c  lb    x24, 1(x20)
001a4c83 1 19 000000fb 00000070  lbu   x25, 1(x20)
01028463 0 00 00000000 00000078  beq   x5, x16, +8 taken
00428463 0 00 00000000 0000007c  beq   x5, x4, +8 not taken
00429463 0 00 00000000 00000084  bne   x5, x4, +8 taken
01029463 0 00 00000000 00000088  bne   x5, x16, +8 not taken
0051c463 0 00 00000000 00000090  blt   x3, x5, +8 taken
0032c463 0 00 00000000 00000094  blt   x5, x3, +8 not taken
ff02dee3 0 00 00000000 00000090  bge   x5, x16, -4 taken on equal
0051d463 0 00 00000000 00000094  bge   x3, x5, +8 not taken
0032e463 0 00 00000000 0000009c  bltu  x5, x3, +8 taken
0051e463 0 00 00000000 000000a0  bltu  x3, x5, +8 not taken
0102f463 0 00 00000000 000000a8  bgeu  x5, x16, +8 taken on equal
0032f463 0 00 00000000 000000ac  bgeu  x5, x3, +8 not taken
010000ef 1 01 000000b0 000000bc  jal   x1, +16
001a0d67 1 1a 000000c0 00000040  jalr  x26, 1(x20)
02428db3 0 00 00000000 00000044  mul   x27, x5, x4 as a no-op
ffffffff 0 00 00000000 00000048  unknown opcode
00850e33 1 1c 00000fed 0000004c  add   x28, x10, x8
000d8eb3 1 1d 00000000 00000050  add   x29, x27, x0

/* rv_core.f */
+incdir+source
source/rv_pkg.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_result.sv
source/rv_core.sv
sim/rv_core_tb.sv

/* Makefile */
VERILATOR  = verilator
VFLAGS     = --binary --timing
LINT_FLAGS = --lint-only --timing
TOP        = rv_core_tb
FILELIST   = rv_core.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
